// File: spi_io.f
common/io_map_pkg.sv
common/spi_pkg.sv
spi/spi_engine.sv
spi/spi_port.sv
src/io_regs.sv
src/spi_io_top.sv
sim/spi_io_assert.sv
sim/spi_io_tb.sv

// File: Bender.yml
package:
  name: spi_io

sources:
  # shared packages
  - common/io_map_pkg.sv
  - common/spi_pkg.sv
  # spi controller
  - spi/spi_engine.sv
  - spi/spi_port.sv
  # decoder and top level
  - src/io_regs.sv
  - src/spi_io_top.sv
  # testbench
  - target: test
    files:
      - sim/spi_io_assert.sv
      - sim/spi_io_tb.sv

// File: sim/spi_io_tb.sv
`default_nettype none

module spi_io_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import io_map_pkg::*;
  import spi_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 5;
  localparam int IDLE_LIMIT   = 64;  // longest transfer is 32 cycles

  // cycle budgets per test group, the watchdog allows twice their sum
  localparam int RESET_TEST_CYC = 20;
  localparam int XFER_TEST_CYC  = 8 * 50;
  localparam int PIN_TEST_CYC   = 2 * 20;
  localparam int SYS_TEST_CYC   = 60;
  localparam int WATCHDOG_NS    = 2 * CLK_PERIOD *
    (RESET_CYCLES + RESET_TEST_CYC + XFER_TEST_CYC + PIN_TEST_CYC + SYS_TEST_CYC);

  logic       cpuclk;
  logic       SCKclock;
  io_bus_t    bus;
  io_data_t   io_rd;
  spi_pins_t  eve_pins;
  spi_pins_t  flash_pins;
  spi_lanes_t eve_oe;
  spi_lanes_t flash_oe;
  spi_lanes_t eve_lanes;
  spi_lanes_t flash_lanes;
  logic       pd;

  logic       loop_en;         // loopback slave on both ports
  logic       quad_mode [2];   // 0 = eve, 1 = flash
  spi_lanes_t lane_drive [2];  // lane inputs while loopback is off

  string test_name;
  int    test_errors;
  int    tests_ok;
  int    tests_bad;

  spi_io_top u_spi_io_top (
    .cpuclk        (cpuclk),
    .SCKclock      (SCKclock),
    .io_bus_i      (bus),
    .io_rd_o       (io_rd),
    .eve_pins_o    (eve_pins),
    .eve_oe_o      (eve_oe),
    .eve_lanes_i   (eve_lanes),
    .flash_pins_o  (flash_pins),
    .flash_oe_o    (flash_oe),
    .flash_lanes_i (flash_lanes),
    .pd_o          (pd)
  );

  initial begin
    cpuclk = 1'b0;
    forever #(CLK_PERIOD / 2) cpuclk = ~cpuclk;
  end

  // --------------------------------------------------
  // loopback slave
  // --------------------------------------------------
  always_comb begin
    eve_lanes   = lane_drive[0];
    flash_lanes = lane_drive[1];
    if (loop_en) begin
      eve_lanes   = quad_mode[0] ? eve_pins.lanes : {2'b00, eve_pins.lanes[0], 1'b0};
      flash_lanes = quad_mode[1] ? flash_pins.lanes : {2'b00, flash_pins.lanes[0], 1'b0};
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
    $display("Test failed");
    $finish;
  end

  // --------------------------------------------------
  // compare tasks and bookkeeping
  // --------------------------------------------------
  task automatic check_data(input string what, input io_data_t exp, input io_data_t act);
    if (act !== exp) begin
      $display("** Error %s, %s: expected %h, actual %h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error %s, %s: expected %b, actual %b", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_lanes(input string what, input spi_lanes_t exp, input spi_lanes_t act);
    if (act !== exp) begin
      $display("** Error %s, %s: expected %b, actual %b", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic open_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic close_test();
    if (test_errors == 0) begin
      $display("%-24s ok", test_name);
      tests_ok++;
    end else begin
      $display("%-24s %0d errors", test_name, test_errors);
      tests_bad++;
    end
  endtask

  function automatic io_addr_t port_base(input int port);
    return (port != 0) ? ADDR_FLASH_BASE : ADDR_EVE_BASE;
  endfunction

  // --------------------------------------------------
  // bus access, driven on the falling edge
  // --------------------------------------------------
  task automatic bus_write(input io_addr_t addr, input io_data_t data);
    @(negedge cpuclk);
    bus.we    = 1'b1;
    bus.re    = 1'b0;
    bus.addr  = addr;
    bus.wdata = data;
    @(negedge cpuclk);
    bus.we = 1'b0;
  endtask

  task automatic bus_read(input io_addr_t addr, output io_data_t data);
    @(negedge cpuclk);
    bus.we   = 1'b0;
    bus.re   = 1'b1;
    bus.addr = addr;
    #(CLK_PERIOD / 4);  // mid low phase, read mux has settled
    data = io_rd;
  endtask

  // --------------------------------------------------
  // tests
  // --------------------------------------------------
  task automatic reset_test();
    io_data_t rd;
    open_test("reset state");
    bus_read(ADDR_EVE_BASE + OFS_IDLE, rd);
    check_data("eve idle", 16'h0001, rd);
    bus_read(ADDR_FLASH_BASE + OFS_IDLE, rd);
    check_data("flash idle", 16'h0001, rd);
    check_bit("pd", 1'b0, pd);
    check_lanes("eve oe", 4'b1101, eve_oe);
    check_lanes("flash oe", 4'b1101, flash_oe);
    close_test();
  endtask

  task automatic transfer_test(input int port, input logic quad, input logic wide);
    io_addr_t base;
    io_data_t tx;
    io_data_t rd;
    io_data_t expect_rx;
    int       expect_cyc;
    int       low_cyc;
    logic     done;
    base       = port_base(port);
    tx         = io_data_t'($urandom);
    expect_rx  = wide ? {tx[7:0], tx[15:8]} : tx;  // loopback returns the bytes in send order
    expect_cyc = quad ? (wide ? 8 : 4) : (wide ? 32 : 16);
    open_test($sformatf("%s %s %0d-bit", (port != 0) ? "flash" : "eve",
                        quad ? "quad" : "single", wide ? 16 : 8));
    bus_write(base + OFS_DIR, io_data_t'(quad));
    quad_mode[port] = quad;
    bus_write(base + OFS_QUAD, io_data_t'(quad));
    @(negedge cpuclk);
    bus.we    = 1'b1;
    bus.re    = 1'b0;
    bus.addr  = base + (wide ? OFS_START16 : OFS_START8);
    bus.wdata = tx;
    @(negedge cpuclk);
    bus.we   = 1'b0;
    bus.re   = 1'b1;
    bus.addr = base + OFS_IDLE;
    #(CLK_PERIOD / 4);
    check_data("idle after start", 16'h0000, io_rd);
    check_lanes("oe", quad ? 4'b1111 : 4'b1101, (port != 0) ? flash_oe : eve_oe);
    done    = io_rd[0];
    low_cyc = io_rd[0] ? 0 : 1;
    while (!done && low_cyc <= IDLE_LIMIT) begin
      bus_read(base + OFS_IDLE, rd);
      if (rd[0])
        done = 1'b1;
      else
        low_cyc++;
    end
    if (!done) begin
      $display("%s: idle never came back after %0d cycles", test_name, IDLE_LIMIT);
      test_errors++;
    end else begin
      check_data("busy cycles", io_data_t'(expect_cyc), io_data_t'(low_cyc));
    end
    bus_read(base + (wide ? OFS_START16 : OFS_START8), rd);
    check_data("rx word", expect_rx, rd);
    close_test();
  endtask

  task automatic pin_test(input int port);
    io_addr_t   base;
    spi_pins_t  pins_w;
    spi_pins_t  pins_now;
    spi_lanes_t lanes_in;
    io_data_t   rd;
    base     = port_base(port);
    pins_w   = spi_pins_t'($urandom);
    lanes_in = spi_lanes_t'($urandom);
    open_test($sformatf("%s pin register", (port != 0) ? "flash" : "eve"));
    @(negedge cpuclk);
    loop_en          = 1'b0;
    lane_drive[port] = lanes_in;
    bus_write(base + OFS_PINS, io_data_t'(pins_w));
    #(CLK_PERIOD / 4);
    pins_now = (port != 0) ? flash_pins : eve_pins;
    check_bit("cs", pins_w.cs, pins_now.cs);
    check_bit("sck", pins_w.sck, pins_now.sck);
    check_lanes("lane outputs", pins_w.lanes, pins_now.lanes);
    bus_read(base + OFS_PINS, rd);
    check_data("pins read", io_data_t'(lanes_in), rd);
    bus_write(base + OFS_PINS, 16'h0000);
    loop_en          = 1'b1;  // back at a falling edge here
    lane_drive[port] = '0;
    close_test();
  endtask

  task automatic system_test();
    io_data_t val;
    io_data_t rd;
    io_data_t t1;
    io_data_t t2;
    int       k;
    open_test("sysctl, ticks, unmapped");
    val = io_data_t'($urandom) | 16'h0001;
    bus_write(ADDR_SYSCTL, val);
    bus_read(ADDR_SYSCTL, rd);
    check_data("sysctl", val, rd);
    check_bit("pd high", 1'b1, pd);
    val = io_data_t'($urandom) & 16'hfffe;
    bus_write(ADDR_SYSCTL, val);
    bus_read(ADDR_SYSCTL, rd);
    check_data("sysctl", val, rd);
    check_bit("pd low", 1'b0, pd);
    k = 5 + int'($urandom % 20);
    bus_read(ADDR_TICKS, t1);
    repeat (k - 1) @(negedge cpuclk);
    bus_read(ADDR_TICKS, t2);  // k falling edges after the first read
    check_data("tick delta", io_data_t'(k), io_data_t'(t2 - t1));
    bus_read(12'h016, rd);
    check_data("unmapped 016", 16'h0000, rd);
    bus_read(12'h106, rd);
    check_data("unmapped 106", 16'h0000, rd);
    bus_read(12'hfff, rd);
    check_data("unmapped fff", 16'h0000, rd);
    close_test();
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    SCKclock      = 1'b1;
    bus           = '0;
    loop_en       = 1'b1;
    quad_mode[0]  = 1'b0;
    quad_mode[1]  = 1'b0;
    lane_drive[0] = '0;
    lane_drive[1] = '0;
    tests_ok      = 0;
    tests_bad     = 0;
    void'($urandom(32'h175cc70a));
    repeat (RESET_CYCLES) @(negedge cpuclk);
    SCKclock = 1'b0;

    reset_test();
    for (int p = 0; p < 2; p++) begin
      transfer_test(p, 1'b0, 1'b0);
      transfer_test(p, 1'b0, 1'b1);
      transfer_test(p, 1'b1, 1'b0);
      transfer_test(p, 1'b1, 1'b1);
    end
    pin_test(0);
    pin_test(1);
    system_test();

    if (u_spi_io_top.u_spi_io_assert.assert_errors != 0) begin
      $display("bound assertions failed %0d times",
               u_spi_io_top.u_spi_io_assert.assert_errors);
      tests_bad++;
    end
    $display("summary: %0d tests clean, %0d with errors", tests_ok, tests_bad);
    if (tests_bad == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/spi_io_assert.sv
`default_nettype none

module spi_io_assert (
  input wire                        cpuclk,
  input wire                        SCKclock,
  input wire io_map_pkg::io_bus_t   io_bus_i,
  input wire io_map_pkg::io_data_t  io_rd_i,
  input wire spi_pkg::spi_cmd_t     eve_cmd_i,
  input wire spi_pkg::spi_cmd_t     flash_cmd_i,
  input wire spi_pkg::spi_stat_t    eve_stat_i,
  input wire spi_pkg::spi_stat_t    flash_stat_i,
  input wire                        eve_quad_i,
  input wire                        flash_quad_i,
  input wire spi_pkg::spi_lanes_t   eve_oe_i,
  input wire spi_pkg::spi_lanes_t   flash_oe_i
);

  timeunit 1ns;
  timeprecision 100ps;

  import io_map_pkg::*;
  import spi_pkg::*;

  int unsigned assert_errors = 0;  // read by the testbench at the end

  // addresses that put something on the read-back bus
  function automatic logic readable(io_addr_t a);
    if (a == ADDR_SYSCTL || a == ADDR_TICKS)
      return 1'b1;
    if (a >= ADDR_EVE_BASE && a <= io_addr_t'(ADDR_EVE_BASE + OFS_IDLE))
      return 1'b1;
    if (a >= ADDR_FLASH_BASE && a <= io_addr_t'(ADDR_FLASH_BASE + OFS_IDLE))
      return 1'b1;
    return 1'b0;
  endfunction

  // --------------------------------------------------
  // engine start
  // --------------------------------------------------
  eve_busy_after_start: assert property (@(posedge cpuclk) disable iff (SCKclock)
    (eve_cmd_i.start8 || eve_cmd_i.start16) |=> !eve_stat_i.idle)
    else begin
      $error("eve port still idle the cycle after a start strobe");
      assert_errors++;
    end

  flash_busy_after_start: assert property (@(posedge cpuclk) disable iff (SCKclock)
    (flash_cmd_i.start8 || flash_cmd_i.start16) |=> !flash_stat_i.idle)
    else begin
      $error("flash port still idle the cycle after a start strobe");
      assert_errors++;
    end

  // unmapped reads stay quiet
  unmapped_reads_zero: assert property (@(posedge cpuclk) disable iff (SCKclock)
    !readable(io_bus_i.addr) |-> (io_rd_i == '0))
    else begin
      $error("nonzero read data at unmapped address %h", io_bus_i.addr);
      assert_errors++;
    end

  // --------------------------------------------------
  // output enables in single mode
  // --------------------------------------------------
  eve_single_oe: assert property (@(posedge cpuclk) disable iff (SCKclock)
    !eve_quad_i |-> (eve_oe_i == OE_SINGLE))
    else begin
      $error("eve output enables %b outside quad mode", eve_oe_i);
      assert_errors++;
    end

  flash_single_oe: assert property (@(posedge cpuclk) disable iff (SCKclock)
    !flash_quad_i |-> (flash_oe_i == OE_SINGLE))
    else begin
      $error("flash output enables %b outside quad mode", flash_oe_i);
      assert_errors++;
    end

endmodule

bind spi_io_top spi_io_assert u_spi_io_assert (
  .cpuclk       (cpuclk),
  .SCKclock     (SCKclock),
  .io_bus_i     (io_bus_i),
  .io_rd_i      (io_rd_o),
  .eve_cmd_i    (eve_cmd),
  .flash_cmd_i  (flash_cmd),
  .eve_stat_i   (eve_stat),
  .flash_stat_i (flash_stat),
  .eve_quad_i   (u_eve.quad_q),
  .flash_quad_i (u_flash.quad_q),
  .eve_oe_i     (eve_oe_o),
  .flash_oe_i   (flash_oe_o)
);

`default_nettype wire

// File: src/spi_io_top.sv
`default_nettype none

module spi_io_top (
  input  wire                        cpuclk,
  input  wire                        SCKclock,
  input  wire io_map_pkg::io_bus_t   io_bus_i,
  output wire io_map_pkg::io_data_t  io_rd_o,
  // eve (graphics chip) port
  output wire spi_pkg::spi_pins_t    eve_pins_o,
  output wire spi_pkg::spi_lanes_t   eve_oe_o,     // 1 = lane driven
  input  wire spi_pkg::spi_lanes_t   eve_lanes_i,
  // flash port
  output wire spi_pkg::spi_pins_t    flash_pins_o,
  output wire spi_pkg::spi_lanes_t   flash_oe_o,
  input  wire spi_pkg::spi_lanes_t   flash_lanes_i,
  output wire                        pd_o
);

  import io_map_pkg::*;
  import spi_pkg::*;

  wire spi_cmd_t  eve_cmd;
  wire spi_cmd_t  flash_cmd;
  wire spi_stat_t eve_stat;
  wire spi_stat_t flash_stat;
  wire io_data_t  wdata;

  io_regs u_io_regs (
    .cpuclk       (cpuclk),
    .SCKclock     (SCKclock),
    .io_bus_i     (io_bus_i),
    .eve_stat_i   (eve_stat),
    .flash_stat_i (flash_stat),
    .eve_cmd_o    (eve_cmd),
    .flash_cmd_o  (flash_cmd),
    .wdata_o      (wdata),
    .io_rd_o      (io_rd_o),
    .pd_o         (pd_o)
  );

  // both ports are the same block, the decoder alone tells them apart
  spi_port u_eve (
    .cpuclk   (cpuclk),
    .SCKclock (SCKclock),
    .cmd_i    (eve_cmd),
    .wdata_i  (wdata),
    .lanes_i  (eve_lanes_i),
    .stat_o   (eve_stat),
    .pins_o   (eve_pins_o),
    .oe_o     (eve_oe_o)
  );

  spi_port u_flash (
    .cpuclk   (cpuclk),
    .SCKclock (SCKclock),
    .cmd_i    (flash_cmd),
    .wdata_i  (wdata),
    .lanes_i  (flash_lanes_i),
    .stat_o   (flash_stat),
    .pins_o   (flash_pins_o),
    .oe_o     (flash_oe_o)
  );

endmodule

`default_nettype wire

// File: src/io_regs.sv
`default_nettype none

module io_regs (
  input  wire                        cpuclk,
  input  wire                        SCKclock,
  input  wire io_map_pkg::io_bus_t   io_bus_i,
  input  wire spi_pkg::spi_stat_t    eve_stat_i,
  input  wire spi_pkg::spi_stat_t    flash_stat_i,
  output spi_pkg::spi_cmd_t          eve_cmd_o,
  output spi_pkg::spi_cmd_t          flash_cmd_o,
  output io_map_pkg::io_data_t       wdata_o,
  output io_map_pkg::io_data_t       io_rd_o,
  output logic                       pd_o
);

  import io_map_pkg::*;
  import spi_pkg::*;

  io_data_t sysctl;
  io_data_t ticks;

  // --------------------------------------------------
  // per-port decode, shared by both windows
  // --------------------------------------------------
  function automatic spi_cmd_t port_cmd(io_bus_t bus, io_addr_t base);
    spi_cmd_t cmd;
    cmd.pins_we = bus.we && (bus.addr == io_addr_t'(base + OFS_PINS));
    cmd.start8  = bus.we && (bus.addr == io_addr_t'(base + OFS_START8));
    cmd.start16 = bus.we && (bus.addr == io_addr_t'(base + OFS_START16));
    cmd.dir_we  = bus.we && (bus.addr == io_addr_t'(base + OFS_DIR));
    cmd.quad_we = bus.we && (bus.addr == io_addr_t'(base + OFS_QUAD));
    return cmd;
  endfunction

  function automatic io_data_t port_rd(io_addr_t addr, io_addr_t base, spi_stat_t stat);
    io_data_t rd;
    rd = '0;
    if (addr == io_addr_t'(base + OFS_PINS))
      rd = io_data_t'(stat.lanes);
    if (addr == io_addr_t'(base + OFS_START8) || addr == io_addr_t'(base + OFS_START16))
      rd = stat.rx;
    if (addr == io_addr_t'(base + OFS_IDLE))
      rd = io_data_t'(stat.idle);
    return rd;
  endfunction

  assign eve_cmd_o   = port_cmd(io_bus_i, ADDR_EVE_BASE);
  assign flash_cmd_o = port_cmd(io_bus_i, ADDR_FLASH_BASE);
  assign wdata_o     = io_bus_i.wdata;  // shared by both ports

  // --------------------------------------------------
  // system registers
  // --------------------------------------------------
  always_ff @(posedge cpuclk or posedge SCKclock) begin
    if (SCKclock) begin
      sysctl <= '0;
      ticks  <= '0;
    end else begin
      ticks <= ticks + 1'b1;  // free-running
      if (io_bus_i.we && io_bus_i.addr == ADDR_SYSCTL)
        sysctl <= io_bus_i.wdata;
    end
  end

  assign pd_o = sysctl[0];  // eve power-down pin

  // read-back, unmapped addresses fall through as zero
  assign io_rd_o =
    port_rd(io_bus_i.addr, ADDR_EVE_BASE, eve_stat_i) |
    port_rd(io_bus_i.addr, ADDR_FLASH_BASE, flash_stat_i) |
    ((io_bus_i.addr == ADDR_SYSCTL) ? sysctl : '0) |
    ((io_bus_i.addr == ADDR_TICKS)  ? ticks  : '0);

endmodule

`default_nettype wire

// File: spi/spi_port.sv
`default_nettype none

module spi_port (
  input  wire                        cpuclk,
  input  wire                        SCKclock,
  input  wire spi_pkg::spi_cmd_t     cmd_i,
  input  wire io_map_pkg::io_data_t  wdata_i,
  input  wire spi_pkg::spi_lanes_t   lanes_i,
  output spi_pkg::spi_stat_t         stat_o,
  output spi_pkg::spi_pins_t         pins_o,
  output spi_pkg::spi_lanes_t        oe_o
);

  import io_map_pkg::*;
  import spi_pkg::*;

  spi_pins_t pin_reg;   // manual cs/sck/lane levels
  logic      dir_q;     // 1 = lanes driven in quad mode
  logic      quad_q;
  spi_pins_t eng_pins;
  io_data_t  eng_rx;
  logic      eng_idle;

  // --------------------------------------------------
  // software registers
  // --------------------------------------------------
  always_ff @(posedge cpuclk or posedge SCKclock) begin
    if (SCKclock) begin
      pin_reg <= '0;
      dir_q   <= 1'b0;
      quad_q  <= 1'b0;
    end else begin
      if (cmd_i.pins_we)
        pin_reg <= spi_pins_t'(wdata_i[$bits(spi_pins_t)-1:0]);
      if (cmd_i.dir_we)
        dir_q <= wdata_i[0];
      if (cmd_i.quad_we)
        quad_q <= wdata_i[0];
    end
  end

  spi_engine u_engine (
    .cpuclk    (cpuclk),
    .SCKclock  (SCKclock),
    .start8_i  (cmd_i.start8),
    .start16_i (cmd_i.start16),
    .tx_i      (wdata_i),
    .lanes_i   (lanes_i),
    .quad_i    (quad_q),
    .dir_i     (dir_q),
    .rx_o      (eng_rx),
    .idle_o    (eng_idle),
    .pins_o    (eng_pins),
    .oe_o      (oe_o)
  );

  // pin register is ORed on top of the engine, so cs can be held high
  // around a transfer or the pins bit-banged while the engine idles
  assign pins_o = spi_pins_t'(pin_reg | eng_pins);

  assign stat_o = '{rx: eng_rx, idle: eng_idle, lanes: lanes_i};

endmodule

`default_nettype wire

// File: spi/spi_engine.sv
`default_nettype none

module spi_engine (
  input  wire                          cpuclk,
  input  wire                          SCKclock,
  input  wire                          start8_i,
  input  wire                          start16_i,
  input  wire io_map_pkg::io_data_t    tx_i,
  input  wire spi_pkg::spi_lanes_t     lanes_i,
  input  wire                          quad_i,
  input  wire                          dir_i,
  output io_map_pkg::io_data_t         rx_o,
  output logic                         idle_o,
  output spi_pkg::spi_pins_t           pins_o,
  output spi_pkg::spi_lanes_t          oe_o
);

  import io_map_pkg::*;
  import spi_pkg::*;

  logic       running;
  spi_cnt_t   count;
  spi_cnt_t   count_nxt;
  io_data_t   shifter;
  io_data_t   tx_swap;
  logic       sck;
  logic       start;
  spi_lanes_t lanes_drv;

  assign start     = start8_i | start16_i;
  assign count_nxt = count + (quad_i ? STEP_QUAD : STEP_SINGLE);
  assign tx_swap   = {tx_i[7:0], tx_i[15:8]};  // low byte goes out first

  // the chosen counter bit flips on every step in both modes
  assign sck = quad_i ? count[2] : count[0];

  // --------------------------------------------------
  // run control
  // --------------------------------------------------
  always_ff @(posedge cpuclk or posedge SCKclock) begin
    if (SCKclock) begin
      running <= 1'b0;
      count   <= '0;
    end else if (start8_i) begin
      running <= 1'b1;
      count   <= CNT_START8;
    end else if (start16_i) begin
      running <= 1'b1;
      count   <= CNT_START16;
    end else if (running) begin
      running <= (count_nxt != '0);  // done on wrap to zero
      count   <= count_nxt;
    end
  end

  // data path shifts on cycles with sck high
  always_ff @(posedge cpuclk) begin
    if (start) begin
      shifter <= tx_swap;
    end else if (running && sck) begin
      if (quad_i)
        shifter <= {shifter[IO_DATA_W-5:0], lanes_i};
      else
        shifter <= {shifter[IO_DATA_W-2:0], lanes_i[LANE_MISO]};
    end
  end

  // --------------------------------------------------
  // pin side
  // --------------------------------------------------
  always_comb begin
    lanes_drv = '0;  // quiet while idle so the pin register shows through
    if (running) begin
      if (quad_i)
        lanes_drv = shifter[IO_DATA_W-1 -: SPI_LANES];
      else
        lanes_drv = {3'b000, shifter[IO_DATA_W-1]};  // mosi only
    end
  end

  assign pins_o = '{cs: 1'b0, sck: sck, lanes: lanes_drv};

  // quad lanes all follow dir while single mode keeps miso as input
  assign oe_o = quad_i ? {SPI_LANES{dir_i}} : OE_SINGLE;

  assign rx_o   = shifter;
  assign idle_o = ~running;

endmodule

`default_nettype wire

// File: common/spi_pkg.sv
`default_nettype none

package spi_pkg;

  localparam int SPI_LANES = 4;
  localparam int SPI_CNT_W = 5;

  typedef logic [SPI_LANES-1:0] spi_lanes_t;  // io3 io2 miso mosi
  typedef logic [SPI_CNT_W-1:0] spi_cnt_t;

  // pin order is cs, sck, io3, io2, miso, mosi
  typedef struct packed {
    logic       cs;
    logic       sck;
    spi_lanes_t lanes;
  } spi_pins_t;

  // one-cycle strobes out of the address decoder
  typedef struct packed {
    logic pins_we;
    logic start8;
    logic start16;
    logic dir_we;
    logic quad_we;
  } spi_cmd_t;

  // what a port hands back to the read mux
  typedef struct packed {
    io_map_pkg::io_data_t rx;
    logic                 idle;
    spi_lanes_t           lanes;
  } spi_stat_t;

  // --------------------------------------------------
  // engine constants
  // --------------------------------------------------
  localparam spi_cnt_t CNT_START8  = 5'd16;  // half the counter range
  localparam spi_cnt_t CNT_START16 = 5'd0;   // full counter range
  localparam spi_cnt_t STEP_SINGLE = 5'd1;
  localparam spi_cnt_t STEP_QUAD   = 5'd4;

  localparam spi_lanes_t OE_SINGLE = 4'b1101;  // miso stays an input
  localparam int         LANE_MISO = 1;

endpackage

`default_nettype wire

// File: common/io_map_pkg.sv
`default_nettype none

package io_map_pkg;

  // --------------------------------------------------
  // bus widths
  // --------------------------------------------------
  localparam int IO_ADDR_W = 12;
  localparam int IO_DATA_W = 16;

  typedef logic [IO_ADDR_W-1:0] io_addr_t;  // decoded i/o address
  typedef logic [IO_DATA_W-1:0] io_data_t;  // one i/o data word

  // cpu side of the i/o bus, plain strobes with no handshake
  typedef struct packed {
    logic     we;     // write strobe
    logic     re;     // read strobe
    io_addr_t addr;
    io_data_t wdata;
  } io_bus_t;

  // --------------------------------------------------
  // register map
  // --------------------------------------------------
  localparam io_addr_t ADDR_SYSCTL     = 12'h014;  // bit 0 is eve power-down
  localparam io_addr_t ADDR_TICKS      = 12'h015;  // free-running counter

  localparam io_addr_t ADDR_EVE_BASE   = 12'h100;
  localparam io_addr_t ADDR_FLASH_BASE = 12'h110;

  // offsets inside one spi port window
  localparam io_addr_t OFS_PINS    = 12'd0;  // wr pin reg, rd input lanes
  localparam io_addr_t OFS_START8  = 12'd1;  // wr starts 8 bits, rd rx word
  localparam io_addr_t OFS_START16 = 12'd2;  // wr starts 16 bits, rd rx word
  localparam io_addr_t OFS_IDLE    = 12'd3;
  localparam io_addr_t OFS_DIR     = 12'd4;
  localparam io_addr_t OFS_QUAD    = 12'd5;

endpackage

`default_nettype wire
